//--- bench/dcache_checker.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_checker (
    input  logic        CLK,
    input  logic        n_rst,
    input  logic        dmem_ren,
    input  logic        dmem_wen,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_store,
    input  logic        halt,
    input  logic        dhit,
    input  logic [31:0] dmem_load,
    input  logic        halted,
    input  logic        ram_valid,
    input  logic        ram_write,
    input  logic [31:0] ram_addr,
    input  logic [31:0] ram_wdata,
    input  logic        ram_ready,
    input  int          entry_num,
    input  logic        exp_hit,
    output int          tests,
    output int          errors
);
    // reference cache.
    logic        mvalid [2][8];
    logic        mdirty [2][8];
    logic [25:0] mtag [2][8];
    logic [31:0] mdata [2][8][2];
    logic        mlru [8];
    logic [31:0] mem_img [logic [31:0]];

    // RAM transfers the DUT still owes in issue order.
    logic        q_write [$];
    logic [31:0] q_addr [$];
    logic [31:0] q_data [$];

    int          hits;
    int          test_errs;
    logic        busy;
    logic        m_hit;
    logic [31:0] exp_load;
    logic [31:0] cur_addr;
    logic        cur_store;
    logic        halt_seen;
    logic        halted_seen;
    logic        prev_stall;
    logic        p_write;
    logic [31:0] p_addr;
    logic [31:0] p_wdata;

    initial begin
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 8; s++) begin
                mvalid[w][s] = 1'b0;
                mdirty[w][s] = 1'b0;
                mlru[s] = 1'b0;
            end
        end
        hits = 0;
        tests = 0;
        errors = 0;
        test_errs = 0;
        busy = 1'b0;
        halt_seen = 1'b0;
        halted_seen = 1'b0;
        prev_stall = 1'b0;
    end

    function automatic logic [31:0] read_img(logic [31:0] a);
        if (mem_img.exists(a)) begin
            return mem_img[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic fault(string msg);
        $display("t=%0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic expect_xfer(logic wr, logic [31:0] a, logic [31:0] d);
        q_write.push_back(wr);
        q_addr.push_back(a);
        q_data.push_back(d);
    endtask

    task automatic finish_test(string what);
        tests++;
        $display("test %0d %s %h: %s", entry_num, what, cur_addr,
                 test_errs == 0 ? "ok" : "FAILED");
    endtask

    task automatic start_access();
        logic [2:0]  idx;
        logic [25:0] tg;
        logic        off;
        logic        w;
        logic [31:0] base;
        idx = dmem_addr[5:3];
        tg = dmem_addr[31:6];
        off = dmem_addr[2];
        m_hit = 1'b0;
        w = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (mvalid[k][idx] && mtag[k][idx] == tg) begin
                m_hit = 1'b1;
                w = k[0];
            end
        end
        if (m_hit) begin
            hits++;
        end else begin
            w = mlru[idx];
            if (mvalid[w][idx] && mdirty[w][idx]) begin   // dirty victim goes out first.
                base = {mtag[w][idx], idx, 3'b000};
                expect_xfer(1'b1, base, mdata[w][idx][0]);
                expect_xfer(1'b1, base + 4, mdata[w][idx][1]);
                mem_img[base] = mdata[w][idx][0];
                mem_img[base + 4] = mdata[w][idx][1];
            end
            base = {tg, idx, 3'b000};
            expect_xfer(1'b0, base, '0);
            expect_xfer(1'b0, base + 4, '0);
            mdata[w][idx][0] = read_img(base);
            mdata[w][idx][1] = read_img(base + 4);
            mvalid[w][idx] = 1'b1;
            mdirty[w][idx] = 1'b0;
            mtag[w][idx] = tg;
        end
        if (dmem_wen) begin
            mdata[w][idx][off] = dmem_store;
            mdirty[w][idx] = 1'b1;
        end
        mlru[idx] = ~w;
        exp_load = mdata[w][idx][off];
        if (m_hit !== exp_hit) begin
            fault("reference model and stimulus table disagree on hit class");
        end
    endtask

    always @(negedge CLK) begin
        logic        qw;
        logic [31:0] qa;
        logic [31:0] qd;
        if (n_rst) begin
            if (prev_stall) begin
                if (!ram_valid) begin
                    fault("RAM request withdrawn before it was accepted");
                end else begin
                    check_value("ram_write", {31'b0, p_write}, {31'b0, ram_write});
                    check_value("ram_addr", p_addr, ram_addr);
                    if (p_write) begin
                        check_value("ram_wdata", p_wdata, ram_wdata);
                    end
                end
            end
            prev_stall = ram_valid && !ram_ready;
            p_write = ram_write;
            p_addr = ram_addr;
            p_wdata = ram_wdata;

            if (halted_seen && ram_valid) begin
                fault("RAM request issued after halt");
            end
            if (ram_valid && ram_ready) begin
                if (q_addr.size() == 0) begin
                    fault("unexpected RAM transfer");
                end else begin
                    qw = q_write.pop_front();
                    qa = q_addr.pop_front();
                    qd = q_data.pop_front();
                    check_value("ram_write", {31'b0, qw}, {31'b0, ram_write});
                    check_value("ram_addr", qa, ram_addr);
                    if (qw) begin
                        check_value("ram_wdata", qd, ram_wdata);
                    end
                end
            end

            if (halted && !halt_seen) begin
                fault("halted high before any halt request");
            end
            if (halted_seen && !halted) begin
                fault("halted dropped after rising");
            end

            if (!busy && !halt_seen && halt) begin
                halt_seen = 1'b1;
                test_errs = 0;
                cur_addr = `DC_COUNT_ADDR;
                expect_xfer(1'b1, `DC_COUNT_ADDR, hits);
                for (int w = 0; w < 2; w++) begin
                    for (int s = 0; s < 8; s++) begin
                        mvalid[w][s] = 1'b0;   // dirty data stays unflushed.
                    end
                end
            end
            if (halt_seen && halted && !halted_seen) begin
                halted_seen = 1'b1;
                if (q_addr.size() != 0) begin
                    fault("halted rose before the hit count write");
                end
                finish_test("halt");
            end

            if (!busy && !halt_seen && (dmem_ren || dmem_wen)) begin
                test_errs = 0;
                cur_addr = dmem_addr;
                cur_store = dmem_wen;
                start_access();
                busy = 1'b1;
                check_value("dhit", {31'b0, m_hit}, {31'b0, dhit});   // first cycle.
            end
            if (busy && dhit) begin
                if (!cur_store) begin
                    check_value("dmem_load", exp_load, dmem_load);
                end
                if (q_addr.size() != 0) begin
                    fault("request completed with RAM transfers still missing");
                end
                finish_test(cur_store ? "store" : "load");
                busy = 1'b0;
            end
        end
    end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    localparam int N_ENTRIES = 15;
    localparam int OP_LOAD = 0;
    localparam int OP_STORE = 1;
    localparam int OP_HALT = 2;

    logic        CLK;
    logic        n_rst;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_store;
    logic        halt;
    logic        dhit;
    logic [31:0] dmem_load;
    logic        halted;
    logic        ram_valid;
    logic        ram_write;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic        ram_ready;
    logic        ram_rvalid;
    logic [31:0] ram_rdata;

    int          tab_op [N_ENTRIES];
    logic [31:0] tab_addr [N_ENTRIES];
    logic [31:0] tab_data [N_ENTRIES];
    logic        tab_hit [N_ENTRIES];

    int          entry_num;
    logic        exp_hit;
    int          tests;
    int          errors;
    int          cycles;
    logic [31:0] ram_mem [logic [31:0]];

    dcache_top dut_i (.*);

    dcache_checker checker_i (.*);

    always #20 CLK = ~CLK;

    task automatic set_entry(int i, int op, logic [31:0] a, logic [31:0] d, logic h);
        tab_op[i] = op;
        tab_addr[i] = a;
        tab_data[i] = d;
        tab_hit[i] = h;
    endtask

    function automatic logic [31:0] ram_read(logic [31:0] a);
        if (ram_mem.exists(a)) begin
            return ram_mem[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    // RAM model answers after the rising edge and samples at the falling one.
    initial begin
        logic [31:0] rd_addr;
        int          rd_cnt;
        void'($urandom(32'h2583));
        rd_cnt = 0;
        rd_addr = '0;
        ram_ready = 1'b0;
        ram_rvalid = 1'b0;
        ram_rdata = '0;
        forever begin
            @(posedge CLK);
            #5;
            ram_ready = ($urandom % 4) != 0;
            ram_rvalid = 1'b0;
            if (rd_cnt > 0) begin
                rd_cnt--;
                if (rd_cnt == 0) begin
                    ram_rvalid = 1'b1;
                    ram_rdata = ram_read(rd_addr);
                end
            end
            @(negedge CLK);
            if (n_rst && ram_valid && ram_ready) begin
                if (ram_write) begin
                    ram_mem[ram_addr] = ram_wdata;
                end else begin
                    rd_addr = ram_addr;
                    rd_cnt = ($urandom % 3) + 1;
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > 200 * N_ENTRIES) begin
            $display("timeout: the DUT stopped responding after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        CLK = 1'b0;
        n_rst = 1'b0;
        cycles = 0;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        dmem_addr = '0;
        dmem_store = '0;
        halt = 1'b0;
        entry_num = 0;
        exp_hit = 1'b0;

        set_entry(0,  OP_LOAD,  32'h0000, 32'h0, 1'b0);
        set_entry(1,  OP_LOAD,  32'h0004, 32'h0, 1'b1);
        set_entry(2,  OP_STORE, 32'h0004, 32'h1111_0004, 1'b1);
        set_entry(3,  OP_LOAD,  32'h1000, 32'h0, 1'b0);
        set_entry(4,  OP_STORE, 32'h1004, 32'h2222_1004, 1'b1);
        set_entry(5,  OP_LOAD,  32'h2000, 32'h0, 1'b0);   // evicts dirty 0x0000.
        set_entry(6,  OP_LOAD,  32'h0004, 32'h0, 1'b0);   // evicts dirty 0x1000.
        set_entry(7,  OP_STORE, 32'h0048, 32'h3333_0048, 1'b0);
        set_entry(8,  OP_LOAD,  32'h0048, 32'h0, 1'b1);
        set_entry(9,  OP_STORE, 32'h2004, 32'h4444_2004, 1'b1);
        set_entry(10, OP_LOAD,  32'h1004, 32'h0, 1'b0);   // clean victim.
        set_entry(11, OP_LOAD,  32'h3000, 32'h0, 1'b0);
        set_entry(12, OP_LOAD,  32'h2004, 32'h0, 1'b0);
        set_entry(13, OP_LOAD,  32'h004C, 32'h0, 1'b1);
        set_entry(14, OP_HALT,  32'h0, 32'h0, 1'b0);

        repeat (2) @(posedge CLK);
        #5;
        n_rst = 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge CLK);
            #5;
            entry_num = i;
            exp_hit = tab_hit[i];
            dmem_addr = tab_addr[i];
            dmem_store = tab_data[i];
            dmem_ren = (tab_op[i] == OP_LOAD);
            dmem_wen = (tab_op[i] == OP_STORE);
            halt = (tab_op[i] == OP_HALT);
            if (tab_op[i] == OP_HALT) begin
                do @(negedge CLK); while (!halted);
            end else begin
                do @(negedge CLK); while (!dhit);
            end
        end
        @(posedge CLK);
        #5;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        halt = 1'b0;
        repeat (10) @(negedge CLK);   // watch for stray traffic.

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests == N_ENTRIES) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry.
`define DC_SETS   8
`define DC_IDX_W  3
`define DC_WORDS  2

// address and data widths.
`define DC_TAG_W  26
`define DC_WORD_W 32

// hit count lands here at halt.
`define DC_COUNT_ADDR 32'h3100

`endif

//--- list.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_ways.sv
logic/dcache_ctrl.sv
logic/ram_port.sv
logic/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  logic                 dmem_ren,
    input  logic                 dmem_wen,
    input  logic                 halt,
    input  dcache_pkg::word_t    dmem_addr,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  logic [`DC_TAG_W-1:0] victim_tag,
    input  dcache_pkg::word_t    victim_data0,
    input  dcache_pkg::word_t    victim_data1,
    input  logic                 mem_wait,
    input  dcache_pkg::word_t    mem_load,
    output logic                 dhit,
    output logic                 halted,
    output dcache_pkg::way_op_t  way_op,
    output logic                 op_way,
    output dcache_pkg::word_t    fill_data,
    output logic                 touch,
    output logic                 touch_way,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output dcache_pkg::word_t    mem_addr,
    output dcache_pkg::word_t    mem_store
);
    import dcache_pkg::*;

    dc_state_t state;
    dc_state_t next_state;
    word_t hit_count;
    word_t next_hit_count;
    logic real_hit;        // low on the first idle cycle after a fill.
    logic next_real_hit;
    dcachef_t req;
    logic req_valid;

    assign req = dcachef_t'(dmem_addr);
    assign req_valid = dmem_ren | dmem_wen;
    assign halted = (state == S_HALTED);

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state <= S_IDLE;
            hit_count <= '0;
            real_hit <= 1'b1;
        end else begin
            state <= next_state;
            hit_count <= next_hit_count;
            real_hit <= next_real_hit;
        end
    end

    always_comb begin
        next_state = state;
        next_hit_count = hit_count;
        next_real_hit = 1'b1;

        dhit = 1'b0;
        way_op = WOP_NONE;
        op_way = victim_way;
        fill_data = mem_load;
        touch = 1'b0;
        touch_way = victim_way;

        mem_ren = 1'b0;
        mem_wen = 1'b0;
        mem_addr = '0;
        mem_store = '0;

        case (state)
            S_IDLE: begin
                if (halt) begin
                    way_op = WOP_INVAL;
                    next_state = S_CNT_WRITE;
                end else if (req_valid && hit) begin
                    dhit = 1'b1;
                    touch = 1'b1;
                    touch_way = hit_way;
                    op_way = hit_way;
                    if (dmem_wen) begin
                        way_op = WOP_WRITE;
                    end
                    if (real_hit) begin
                        next_hit_count = hit_count + 1'b1;
                    end
                end else if (req_valid) begin
                    next_state = victim_dirty ? S_WB0 : S_FILL0;
                end
            end

            // write-back of the victim, block aligned on its own tag.
            S_WB0: begin
                mem_wen = 1'b1;
                mem_addr = {victim_tag, req.idx, 1'b0, 2'b00};
                mem_store = victim_data0;
                if (!mem_wait) begin
                    next_state = S_WB1;
                end
            end
            S_WB1: begin
                mem_wen = 1'b1;
                mem_addr = {victim_tag, req.idx, 1'b1, 2'b00};
                mem_store = victim_data1;
                if (!mem_wait) begin
                    next_state = S_FILL0;
                end
            end

            S_FILL0: begin
                mem_ren = 1'b1;
                mem_addr = {req.tag, req.idx, 1'b0, 2'b00};
                if (!mem_wait) begin
                    way_op = WOP_FILL0;
                    next_state = S_FILL1;
                end
            end
            S_FILL1: begin
                mem_ren = 1'b1;
                mem_addr = {req.tag, req.idx, 1'b1, 2'b00};
                if (!mem_wait) begin
                    way_op = WOP_FILL1;
                    next_real_hit = 1'b0;   // the retry hit is not genuine.
                    next_state = dmem_wen ? S_UPDATE : S_IDLE;
                end
            end

            // store miss merges its word into the new line.
            S_UPDATE: begin
                dhit = 1'b1;
                way_op = WOP_WRITE;
                touch = 1'b1;
                next_state = S_IDLE;
            end

            S_CNT_WRITE: begin
                mem_wen = 1'b1;
                mem_addr = `DC_COUNT_ADDR;
                mem_store = hit_count;
                if (!mem_wait) begin
                    next_state = S_HALTED;
                end
            end

            S_HALTED: begin
            end

            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    a_mem_excl: assert property (@(posedge CLK) disable iff (!n_rst)
        !(mem_ren && mem_wen));

    // once halted the datapath sees no more completions.
    a_no_dhit_halted: assert property (@(posedge CLK) disable iff (!n_rst)
        halted |-> !dhit);

endmodule

//--- logic/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    // byte address as the cache sees it.
    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic                 blkoff;
        logic [1:0]           bytoff;
    } dcachef_t;

    // one line of one way.
    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [`DC_TAG_W-1:0]  tag;
        word_t [`DC_WORDS-1:0] data;
    } dcache_frame;

    typedef enum logic [2:0] {
        WOP_NONE,
        WOP_FILL0,  // word 0 in, line still invalid.
        WOP_FILL1,  // word 1 in, line becomes valid.
        WOP_WRITE,
        WOP_INVAL
    } way_op_t;

    typedef enum logic [2:0] {
        S_IDLE, S_WB0, S_WB1, S_FILL0, S_FILL1, S_UPDATE, S_CNT_WRITE, S_HALTED
    } dc_state_t;

endpackage

//--- logic/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_top (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  logic              halt,
    output logic              dhit,
    output dcache_pkg::word_t dmem_load,
    output logic              halted,
    output logic              ram_valid,
    output logic              ram_write,
    output dcache_pkg::word_t ram_addr,
    output dcache_pkg::word_t ram_wdata,
    input  logic              ram_ready,
    input  logic              ram_rvalid,
    input  dcache_pkg::word_t ram_rdata
);
    import dcache_pkg::*;

    dcachef_t req;
    way_op_t way_op;
    logic op_way;
    logic touch;
    logic touch_way;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic victim_dirty;
    logic [`DC_TAG_W-1:0] victim_tag;
    word_t fill_data;
    word_t victim_data0;
    word_t victim_data1;
    logic mem_ren;
    logic mem_wen;
    logic mem_wait;
    word_t mem_addr;
    word_t mem_store;
    word_t mem_load;

    assign req = dcachef_t'(dmem_addr);

    dcache_ways ways_i (
        .CLK(CLK), .n_rst(n_rst),
        .idx(req.idx), .tag(req.tag), .blkoff(req.blkoff), .store_data(dmem_store),
        .way_op(way_op), .op_way(op_way), .fill_data(fill_data),
        .touch(touch), .touch_way(touch_way),
        .hit(hit), .hit_way(hit_way), .load_data(dmem_load),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .victim_data0(victim_data0), .victim_data1(victim_data1)
    );

    dcache_ctrl ctrl_i (
        .CLK(CLK), .n_rst(n_rst),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .halt(halt), .dmem_addr(dmem_addr),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .victim_data0(victim_data0), .victim_data1(victim_data1),
        .mem_wait(mem_wait), .mem_load(mem_load),
        .dhit(dhit), .halted(halted), .way_op(way_op), .op_way(op_way),
        .fill_data(fill_data), .touch(touch), .touch_way(touch_way),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store)
    );

    ram_port port_i (
        .CLK(CLK), .n_rst(n_rst),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
        .ram_ready(ram_ready), .ram_rvalid(ram_rvalid), .ram_rdata(ram_rdata),
        .mem_wait(mem_wait), .mem_load(mem_load),
        .ram_valid(ram_valid), .ram_write(ram_write),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

endmodule

//--- logic/dcache_ways.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ways (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  logic [`DC_IDX_W-1:0] idx,
    input  logic [`DC_TAG_W-1:0] tag,
    input  logic                 blkoff,
    input  dcache_pkg::word_t    store_data,
    input  dcache_pkg::way_op_t  way_op,
    input  logic                 op_way,
    input  dcache_pkg::word_t    fill_data,
    input  logic                 touch,
    input  logic                 touch_way,
    output logic                 hit,
    output logic                 hit_way,
    output dcache_pkg::word_t    load_data,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [`DC_TAG_W-1:0] victim_tag,
    output dcache_pkg::word_t    victim_data0,
    output dcache_pkg::word_t    victim_data1
);
    import dcache_pkg::*;

    dcache_frame frames [2][`DC_SETS];
    logic [`DC_SETS-1:0] lru;   // per set, the way to evict next.

    dcache_frame line0;
    dcache_frame line1;
    dcache_frame vline;
    logic hit0;
    logic hit1;

    assign line0 = frames[0][idx];
    assign line1 = frames[1][idx];

    assign hit0 = line0.valid && (line0.tag == tag);
    assign hit1 = line1.valid && (line1.tag == tag);
    assign hit = hit0 | hit1;
    assign hit_way = hit1;

    assign load_data = hit1 ? line1.data[blkoff] : line0.data[blkoff];

    // victim side of the indexed set.
    assign victim_way = lru[idx];
    assign vline = victim_way ? line1 : line0;
    assign victim_dirty = vline.valid && vline.dirty;
    assign victim_tag = vline.tag;
    assign victim_data0 = vline.data[0];
    assign victim_data1 = vline.data[1];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            lru <= '0;
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    frames[w][s].valid <= 1'b0;
                    frames[w][s].dirty <= 1'b0;
                end
            end
        end else begin
            case (way_op)
                WOP_FILL0: begin
                    frames[op_way][idx].valid <= 1'b0;
                    frames[op_way][idx].dirty <= 1'b0;
                    frames[op_way][idx].tag <= tag;
                    frames[op_way][idx].data[0] <= fill_data;
                end
                WOP_FILL1: begin
                    frames[op_way][idx].valid <= 1'b1;
                    frames[op_way][idx].dirty <= 1'b0;
                    frames[op_way][idx].tag <= tag;
                    frames[op_way][idx].data[1] <= fill_data;
                end
                WOP_WRITE: begin
                    // tag stays as it is.
                    frames[op_way][idx].dirty <= 1'b1;
                    frames[op_way][idx].data[blkoff] <= store_data;
                end
                WOP_INVAL: begin
                    for (int w = 0; w < 2; w++) begin
                        for (int s = 0; s < `DC_SETS; s++) begin
                            frames[w][s].valid <= 1'b0;   // dirty bits kept.
                        end
                    end
                end
                default: begin
                end
            endcase

            if (touch) begin
                lru[idx] <= ~touch_way;
            end
        end
    end

    // fills only follow a miss, so no set ever holds one block twice.
    for (genvar s = 0; s < `DC_SETS; s++) begin : g_dup_chk
        a_no_dup_tag: assert property (@(posedge CLK) disable iff (!n_rst)
            !(frames[0][s].valid && frames[1][s].valid &&
              frames[0][s].tag == frames[1][s].tag));
    end

endmodule

//--- logic/ram_port.sv
`timescale 1ns/1ns

module ram_port (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  dcache_pkg::word_t mem_addr,
    input  dcache_pkg::word_t mem_store,
    input  logic              ram_ready,
    input  logic              ram_rvalid,
    input  dcache_pkg::word_t ram_rdata,
    output logic              mem_wait,
    output dcache_pkg::word_t mem_load,
    output logic              ram_valid,
    output logic              ram_write,
    output dcache_pkg::word_t ram_addr,
    output dcache_pkg::word_t ram_wdata
);
    import dcache_pkg::*;

    logic rd_pend;     // read accepted, data not back yet.
    logic rd_accept;
    logic wr_done;
    logic rd_done;

    // no new request while a read is out, including its data cycle.
    // the controller moves on at the edge that ends the completion.
    assign ram_valid = (mem_ren | mem_wen) & ~rd_pend;

    // request fields come straight from the controller, which holds them.
    assign ram_write = mem_wen;
    assign ram_addr = mem_addr;
    assign ram_wdata = mem_store;

    assign rd_accept = ram_valid & ram_ready & ~mem_wen;
    assign wr_done = ram_valid & ram_ready & mem_wen;   // writes finish on acceptance.
    assign rd_done = rd_pend & ram_rvalid;

    assign mem_wait = ~(wr_done | rd_done);
    assign mem_load = rd_done ? ram_rdata : '0;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            rd_pend <= 1'b0;
        end else if (rd_accept) begin
            rd_pend <= 1'b1;
        end else if (rd_done) begin
            rd_pend <= 1'b0;
        end
    end

    // read data must answer a request this port actually issued.
    a_rvalid_pending: assert property (@(posedge CLK) disable iff (!n_rst)
        ram_rvalid |-> rd_pend);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f list.f \
    --top-module dcache_tb \
    -o dcache_sim

# the simulator exits cleanly on both outcomes, so the log decides.
./obj_dir/dcache_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
